// File: Makefile
TOP = mips_cpu_tb

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps -f mips_cpu.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f mips_cpu.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: mips_cpu.f
+incdir+src
src/mips_pkg.sv
src/mips_reg_file.sv
src/mips_alu.sv
src/mips_decoder.sv
src/mips_control.sv
src/mips_datapath.sv
src/mips_cpu.sv
verification/mips_cpu_tb.sv

// File: src/mips_alu.sv
`include "mips_macros.svh"

module mips_alu (
	input  logic [`MIPS_XLEN-1:0] src1,
	input  logic [`MIPS_XLEN-1:0] src2,
	input  mips_pkg::alu_op_e     op,
	output logic [`MIPS_XLEN-1:0] result
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt = src1[4:0]; // Shift amount comes in on src1.
	assign lt_signed = $signed(src1) < $signed(src2);
	assign lt_unsigned = src1 < src2;

	always_comb begin
		result = '0;
		case (op)
			mips_pkg::ALU_ADD: result = src1 + src2;
			mips_pkg::ALU_SUB: result = src1 - src2;
			mips_pkg::ALU_AND: result = src1 & src2;
			mips_pkg::ALU_OR: result = src1 | src2;
			mips_pkg::ALU_XOR: result = src1 ^ src2;
			mips_pkg::ALU_NOR: result = ~(src1 | src2);
			mips_pkg::ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, lt_signed};
			mips_pkg::ALU_SLTU: result = {{(`MIPS_XLEN-1){1'b0}}, lt_unsigned};
			mips_pkg::ALU_SLL: result = src2 << shamt;
			mips_pkg::ALU_SRL: result = src2 >> shamt;
			mips_pkg::ALU_SRA: result = $signed(src2) >>> shamt;
			mips_pkg::ALU_LUI: result = {src2[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

endmodule

// File: src/mips_control.sv
module mips_control (
	input  logic                  clk,
	input  logic                  rst,
	input  mips_pkg::inst_class_e inst_class,
	input  logic                  inst_req_ack,
	input  logic                  inst_valid,
	input  logic                  mem_req_ack,
	input  logic                  read_data_valid,
	output mips_pkg::cpu_state_e  state,
	output logic                  inst_req_valid,
	output logic                  inst_ack,
	output logic                  mem_write,
	output logic                  mem_read,
	output logic                  read_data_ack,
	output logic                  rf_wen
);

	mips_pkg::cpu_state_e next_state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mips_pkg::ST_INIT;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			mips_pkg::ST_INIT: next_state = mips_pkg::ST_FETCH;
			mips_pkg::ST_FETCH: if (inst_req_ack) next_state = mips_pkg::ST_FETCH_WAIT;
			mips_pkg::ST_FETCH_WAIT: if (inst_valid) next_state = mips_pkg::ST_DECODE;
			mips_pkg::ST_DECODE: next_state = mips_pkg::ST_EXECUTE;
			mips_pkg::ST_EXECUTE: begin
				case (inst_class)
					mips_pkg::CLS_ALU, mips_pkg::CLS_LINK: next_state = mips_pkg::ST_WB;
					mips_pkg::CLS_STORE: next_state = mips_pkg::ST_STORE;
					mips_pkg::CLS_LOAD: next_state = mips_pkg::ST_LOAD;
					default: next_state = mips_pkg::ST_FETCH; // Branches, jumps and nops.
				endcase
			end
			mips_pkg::ST_STORE: if (mem_req_ack) next_state = mips_pkg::ST_FETCH;
			mips_pkg::ST_LOAD: if (mem_req_ack) next_state = mips_pkg::ST_READ_WAIT;
			mips_pkg::ST_READ_WAIT: if (read_data_valid) next_state = mips_pkg::ST_WB;
			mips_pkg::ST_WB: next_state = mips_pkg::ST_FETCH;
			default: next_state = mips_pkg::ST_INIT;
		endcase
	end

	assign inst_req_valid = (state == mips_pkg::ST_FETCH);
	assign inst_ack = (state == mips_pkg::ST_FETCH_WAIT);
	assign mem_write = (state == mips_pkg::ST_STORE);
	assign mem_read = (state == mips_pkg::ST_LOAD);
	assign read_data_ack = (state == mips_pkg::ST_READ_WAIT);
	assign rf_wen = (state == mips_pkg::ST_WB); // Only writers reach write-back.

	a_inst_req_hold: assert property (@(posedge clk) disable iff (rst)
		(inst_req_valid && !inst_req_ack) |=> inst_req_valid);

	a_mem_req_hold: assert property (@(posedge clk) disable iff (rst)
		((mem_write || mem_read) && !mem_req_ack) |=>
			(mem_write == $past(mem_write)) && (mem_read == $past(mem_read)));

endmodule

// File: src/mips_cpu.sv
`include "mips_macros.svh"

module mips_cpu (
	input  logic                  clk,
	input  logic                  rst,
	output logic [`MIPS_XLEN-1:0] pc,
	output logic                  inst_req_valid,
	input  logic                  inst_req_ack,
	input  logic [`MIPS_XLEN-1:0] instruction,
	input  logic                  inst_valid,
	output logic                  inst_ack,
	output logic [`MIPS_XLEN-1:0] address,
	output logic                  mem_write,
	output logic [`MIPS_XLEN-1:0] write_data,
	output logic                  mem_read,
	input  logic                  mem_req_ack,
	input  logic [`MIPS_XLEN-1:0] read_data,
	input  logic                  read_data_valid,
	output logic                  read_data_ack
);

	mips_pkg::cpu_state_e  state;
	mips_pkg::inst_class_e inst_class;
	mips_pkg::alu_op_e     alu_op;
	mips_pkg::dest_sel_e   dest_sel;
	logic                  src1_is_shamt;
	logic                  src1_is_pc;
	logic                  src2_sel_imm;
	logic                  imm_zero_ext;
	logic                  src2_is_8;
	logic                  rf_wen;
	logic [`MIPS_XLEN-1:0] inst;

	mips_control u_control (
		.clk            (clk),
		.rst            (rst),
		.inst_class     (inst_class),
		.inst_req_ack   (inst_req_ack),
		.inst_valid     (inst_valid),
		.mem_req_ack    (mem_req_ack),
		.read_data_valid(read_data_valid),
		.state          (state),
		.inst_req_valid (inst_req_valid),
		.inst_ack       (inst_ack),
		.mem_write      (mem_write),
		.mem_read       (mem_read),
		.read_data_ack  (read_data_ack),
		.rf_wen         (rf_wen)
	);

	mips_decoder u_decoder (
		.inst         (inst),
		.inst_class   (inst_class),
		.alu_op       (alu_op),
		.src1_is_shamt(src1_is_shamt),
		.src1_is_pc   (src1_is_pc),
		.src2_sel_imm (src2_sel_imm),
		.imm_zero_ext (imm_zero_ext),
		.src2_is_8    (src2_is_8),
		.dest_sel     (dest_sel)
	);

	mips_datapath u_datapath (
		.clk          (clk),
		.rst          (rst),
		.state        (state),
		.inst_class   (inst_class),
		.alu_op       (alu_op),
		.src1_is_shamt(src1_is_shamt),
		.src1_is_pc   (src1_is_pc),
		.src2_sel_imm (src2_sel_imm),
		.imm_zero_ext (imm_zero_ext),
		.src2_is_8    (src2_is_8),
		.dest_sel     (dest_sel),
		.rf_wen       (rf_wen),
		.instruction  (instruction),
		.read_data    (read_data),
		.inst         (inst),
		.pc           (pc),
		.address      (address),
		.write_data   (write_data)
	);

endmodule

// File: src/mips_datapath.sv
`include "mips_macros.svh"

module mips_datapath (
	input  logic                  clk,
	input  logic                  rst,
	input  mips_pkg::cpu_state_e  state,
	input  mips_pkg::inst_class_e inst_class,
	input  mips_pkg::alu_op_e     alu_op,
	input  logic                  src1_is_shamt,
	input  logic                  src1_is_pc,
	input  logic                  src2_sel_imm,
	input  logic                  imm_zero_ext,
	input  logic                  src2_is_8,
	input  mips_pkg::dest_sel_e   dest_sel,
	input  logic                  rf_wen,
	input  logic [`MIPS_XLEN-1:0] instruction,
	input  logic [`MIPS_XLEN-1:0] read_data,
	output logic [`MIPS_XLEN-1:0] inst,
	output logic [`MIPS_XLEN-1:0] pc,
	output logic [`MIPS_XLEN-1:0] address,
	output logic [`MIPS_XLEN-1:0] write_data
);

	logic [`MIPS_XLEN-1:0]   inst_reg;
	logic [`MIPS_XLEN-1:0]   read_data_reg;
	logic [`MIPS_XLEN-1:0]   next_pc;
	logic [`MIPS_XLEN-1:0]   pc_plus4;
	logic [`MIPS_XLEN-1:0]   br_target;
	logic                    br_go;
	logic                    pc_en;
	logic [15:0]             imm;
	logic [`MIPS_XLEN-1:0]   imm_ext;
	logic [`MIPS_XLEN-1:0]   rs_value;
	logic [`MIPS_XLEN-1:0]   rt_value;
	logic [`MIPS_XLEN-1:0]   alu_src1;
	logic [`MIPS_XLEN-1:0]   alu_src2;
	logic [`MIPS_XLEN-1:0]   alu_result;
	logic [`MIPS_REG_AW-1:0] rf_waddr;
	logic [`MIPS_XLEN-1:0]   rf_wdata;

	// Fetch wait ends on inst_valid, so the last sample taken is the valid word.
	always_ff @(posedge clk) begin
		if (state == mips_pkg::ST_FETCH_WAIT) begin
			inst_reg <= instruction;
		end
		if (state == mips_pkg::ST_READ_WAIT) begin
			read_data_reg <= read_data;
		end
		if (state == mips_pkg::ST_DECODE) begin
			next_pc <= br_go ? br_target : pc_plus4;
		end
	end

	// The pc is only presented in fetch, so it may move once nothing later needs it.
	// jal still reads it for the link value, so it waits for write-back.
	assign pc_en = (state == mips_pkg::ST_EXECUTE && inst_class != mips_pkg::CLS_LINK) ||
		(state == mips_pkg::ST_WB);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `MIPS_RESET_PC;
		end else if (pc_en) begin
			pc <= next_pc;
		end
	end

	assign inst = inst_reg;
	assign imm = inst_reg[15:0];
	assign imm_ext = imm_zero_ext ? {{(`MIPS_XLEN-16){1'b0}}, imm} :
		{{(`MIPS_XLEN-16){imm[15]}}, imm};
	assign pc_plus4 = pc + `MIPS_XLEN'(4);

	assign br_go = (inst_class == mips_pkg::CLS_BRANCH) ?
		((inst_reg[31:26] == mips_pkg::OP_BNE) ? (rs_value != rt_value) :
			(rs_value == rt_value)) :
		(inst_class == mips_pkg::CLS_JUMP || inst_class == mips_pkg::CLS_LINK);
	assign br_target = (inst_class == mips_pkg::CLS_BRANCH) ?
		pc_plus4 + {{(`MIPS_XLEN-18){imm[15]}}, imm, 2'b00} :
		{pc[`MIPS_XLEN-1 -: 4], inst_reg[25:0], 2'b00};

	assign alu_src1 = src1_is_shamt ? {{(`MIPS_XLEN-5){1'b0}}, inst_reg[10:6]} :
		src1_is_pc ? pc : rs_value;
	assign alu_src2 = src2_is_8 ? `MIPS_XLEN'(8) : src2_sel_imm ? imm_ext : rt_value;

	always_comb begin
		case (dest_sel)
			mips_pkg::DEST_RD: rf_waddr = inst_reg[15:11];
			mips_pkg::DEST_LINK: rf_waddr = `MIPS_REG_AW'(`MIPS_LINK_REG);
			default: rf_waddr = inst_reg[20:16];
		endcase
	end

	assign rf_wdata = (inst_class == mips_pkg::CLS_LOAD) ? read_data_reg : alu_result;
	assign address = {alu_result[`MIPS_XLEN-1:2], 2'b00};
	assign write_data = rt_value;

	mips_reg_file u_reg_file (
		.clk   (clk),
		.rst   (rst),
		.raddr1(inst_reg[25:21]),
		.raddr2(inst_reg[20:16]),
		.wen   (rf_wen),
		.waddr (rf_waddr),
		.wdata (rf_wdata),
		.rdata1(rs_value),
		.rdata2(rt_value)
	);

	mips_alu u_alu (
		.src1  (alu_src1),
		.src2  (alu_src2),
		.op    (alu_op),
		.result(alu_result)
	);

endmodule

// File: src/mips_decoder.sv
`include "mips_macros.svh"

module mips_decoder (
	input  logic [`MIPS_XLEN-1:0]  inst,
	output mips_pkg::inst_class_e  inst_class,
	output mips_pkg::alu_op_e      alu_op,
	output logic                   src1_is_shamt,
	output logic                   src1_is_pc,
	output logic                   src2_sel_imm,
	output logic                   imm_zero_ext,
	output logic                   src2_is_8,
	output mips_pkg::dest_sel_e    dest_sel
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = inst[31:26];
	assign funct = inst[5:0];

	always_comb begin
		inst_class = mips_pkg::CLS_NOP;
		alu_op = mips_pkg::ALU_ADD;
		src1_is_shamt = 1'b0;
		src1_is_pc = 1'b0;
		src2_sel_imm = 1'b1; // Most formats take the immediate.
		imm_zero_ext = 1'b0;
		src2_is_8 = 1'b0;
		dest_sel = mips_pkg::DEST_RT;
		case (opcode)
			mips_pkg::OP_SPECIAL: begin
				inst_class = mips_pkg::CLS_ALU;
				src2_sel_imm = 1'b0;
				dest_sel = mips_pkg::DEST_RD;
				case (funct)
					mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR: alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR: alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR: alu_op = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLT: alu_op = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLTU: alu_op = mips_pkg::ALU_SLTU;
					mips_pkg::FN_SLL: alu_op = mips_pkg::ALU_SLL;
					mips_pkg::FN_SRL: alu_op = mips_pkg::ALU_SRL;
					mips_pkg::FN_SRA: alu_op = mips_pkg::ALU_SRA;
					default: inst_class = mips_pkg::CLS_NOP;
				endcase
				src1_is_shamt = alu_op inside {mips_pkg::ALU_SLL, mips_pkg::ALU_SRL,
					mips_pkg::ALU_SRA};
			end
			mips_pkg::OP_ADDIU: inst_class = mips_pkg::CLS_ALU;
			mips_pkg::OP_SLTI: begin
				inst_class = mips_pkg::CLS_ALU;
				alu_op = mips_pkg::ALU_SLT;
			end
			mips_pkg::OP_SLTIU: begin
				inst_class = mips_pkg::CLS_ALU;
				alu_op = mips_pkg::ALU_SLTU;
			end
			mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
				inst_class = mips_pkg::CLS_ALU;
				imm_zero_ext = 1'b1; // Logic immediates are unsigned.
				alu_op = (opcode == mips_pkg::OP_ANDI) ? mips_pkg::ALU_AND :
					(opcode == mips_pkg::OP_ORI) ? mips_pkg::ALU_OR : mips_pkg::ALU_XOR;
			end
			mips_pkg::OP_LUI: begin
				inst_class = mips_pkg::CLS_ALU;
				alu_op = mips_pkg::ALU_LUI;
			end
			mips_pkg::OP_LW: inst_class = mips_pkg::CLS_LOAD;
			mips_pkg::OP_SW: inst_class = mips_pkg::CLS_STORE;
			mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
				inst_class = mips_pkg::CLS_BRANCH;
				src2_sel_imm = 1'b0;
			end
			mips_pkg::OP_J: inst_class = mips_pkg::CLS_JUMP;
			mips_pkg::OP_JAL: begin
				inst_class = mips_pkg::CLS_LINK;
				src1_is_pc = 1'b1; // Link value is pc + 8.
				src2_is_8 = 1'b1;
				dest_sel = mips_pkg::DEST_LINK;
			end
			default: inst_class = mips_pkg::CLS_NOP;
		endcase
	end

endmodule

// File: src/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define MIPS_XLEN 32 // Word width.
`define MIPS_REG_AW 5 // Register address width.
`define MIPS_REG_COUNT 32
`define MIPS_RESET_PC 32'h0000_0000 // First fetch address.
`define MIPS_LINK_REG 31 // Written by jal.

`endif

// File: src/mips_pkg.sv
package mips_pkg;

	typedef enum logic [3:0] {
		ST_INIT,
		ST_FETCH,
		ST_FETCH_WAIT,
		ST_DECODE,
		ST_EXECUTE,
		ST_STORE,
		ST_LOAD,
		ST_READ_WAIT,
		ST_WB
	} cpu_state_e;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000, // Register format, see funct.
		OP_J = 6'b000010,
		OP_JAL = 6'b000011,
		OP_BEQ = 6'b000100,
		OP_BNE = 6'b000101,
		OP_ADDIU = 6'b001001,
		OP_SLTI = 6'b001010,
		OP_SLTIU = 6'b001011,
		OP_ANDI = 6'b001100,
		OP_ORI = 6'b001101,
		OP_XORI = 6'b001110,
		OP_LUI = 6'b001111,
		OP_LW = 6'b100011,
		OP_SW = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL = 6'b000000,
		FN_SRL = 6'b000010,
		FN_SRA = 6'b000011,
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND = 6'b100100,
		FN_OR = 6'b100101,
		FN_XOR = 6'b100110,
		FN_NOR = 6'b100111,
		FN_SLT = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

	typedef enum logic [2:0] {
		CLS_ALU, CLS_BRANCH, CLS_JUMP, CLS_LINK, CLS_LOAD, CLS_STORE, CLS_NOP
	} inst_class_e;

	typedef enum logic [1:0] {
		DEST_RD, DEST_RT, DEST_LINK
	} dest_sel_e;

endpackage

// File: src/mips_reg_file.sv
`include "mips_macros.svh"

module mips_reg_file (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`MIPS_REG_AW-1:0] raddr1,
	input  logic [`MIPS_REG_AW-1:0] raddr2,
	input  logic                    wen,
	input  logic [`MIPS_REG_AW-1:0] waddr,
	input  logic [`MIPS_XLEN-1:0]   wdata,
	output logic [`MIPS_XLEN-1:0]   rdata1,
	output logic [`MIPS_XLEN-1:0]   rdata2
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			regs[0] <= '0; // r0 is cleared here and never written again.
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

	// A write aimed at r0 must never become visible on a read port.
	a_r0_stays_zero: assert property (@(posedge clk) disable iff (rst)
		(raddr1 != '0 || rdata1 == '0) && (raddr2 != '0 || rdata2 == '0));

endmodule

// File: verification/mips_cpu_tb.sv
module mips_cpu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	logic [31:0] pc;
	logic        inst_req_valid;
	logic        inst_req_ack = 1'b0;
	logic [31:0] instruction = '0;
	logic        inst_valid = 1'b0;
	logic        inst_ack;
	logic [31:0] address;
	logic        mem_write;
	logic [31:0] write_data;
	logic        mem_read;
	logic        mem_req_ack = 1'b0;
	logic [31:0] read_data = '0;
	logic        read_data_valid = 1'b0;
	logic        read_data_ack;

	logic [31:0] imem [1024];
	logic [31:0] dmem [256];
	logic [31:0] stall_rng = 32'hfc2f;
	logic [31:0] op_rng = 32'hfc2f;
	logic        fetch_busy = 1'b0;
	logic [31:0] fetch_addr = '0;
	logic        load_busy = 1'b0;
	logic [31:0] load_addr = '0;
	logic        fetched_once = 1'b0;
	logic        halted = 1'b0;
	logic [31:0] halt_addr = '1;
	logic [31:0] store_addr = 32'h200;
	int          prog_len = 0;
	int          pc_idx = 0;
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	string       exp_name [$];
	logic [5:0]  r_functs [11] = '{mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_AND,
		mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_NOR, mips_pkg::FN_SLT,
		mips_pkg::FN_SLTU, mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA};
	logic [5:0]  i_ops [7] = '{mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
		mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI};

	mips_cpu u_mips_cpu (.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] next_random();
		op_rng = xorshift(op_rng);
		return op_rng;
	endfunction

	function automatic logic [31:0] r_type(input logic [5:0] funct, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		return {6'b000000, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] j_type(input logic [5:0] op, input logic [31:0] target);
		return {op, target[27:2]};
	endfunction

	// Results follow the MIPS32 definition of each kept instruction.
	function automatic logic [31:0] expected_result(input logic [31:0] word,
			input logic [31:0] rs_val, input logic [31:0] rt_val);
		logic [31:0] sx;
		logic [31:0] zx;
		logic [4:0]  sh;
		logic [31:0] res;
		sx = {{16{word[15]}}, word[15:0]};
		zx = {16'h0000, word[15:0]};
		sh = word[10:6];
		res = '0;
		case (word[31:26])
			6'h00: begin
				case (word[5:0])
					6'h21: res = rs_val + rt_val;
					6'h23: res = rs_val - rt_val;
					6'h24: res = rs_val & rt_val;
					6'h25: res = rs_val | rt_val;
					6'h26: res = rs_val ^ rt_val;
					6'h27: res = ~(rs_val | rt_val);
					6'h2a: res = ($signed(rs_val) < $signed(rt_val)) ? 32'd1 : 32'd0;
					6'h2b: res = (rs_val < rt_val) ? 32'd1 : 32'd0;
					6'h00: res = rt_val << sh;
					6'h02: res = rt_val >> sh;
					6'h03: res = $signed(rt_val) >>> sh; // Sign bit fills from the left.
					default: res = '0;
				endcase
			end
			6'h09: res = rs_val + sx;
			6'h0a: res = ($signed(rs_val) < $signed(sx)) ? 32'd1 : 32'd0;
			6'h0b: res = (rs_val < sx) ? 32'd1 : 32'd0; // Extended immediate, unsigned compare.
			6'h0c: res = rs_val & zx;
			6'h0d: res = rs_val | zx;
			6'h0e: res = rs_val ^ zx;
			6'h0f: res = {word[15:0], 16'h0000};
			default: res = '0;
		endcase
		return res;
	endfunction

	task automatic abort(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			abort($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	task automatic emit(input logic [31:0] word);
		imem[pc_idx] = word;
		pc_idx++;
	endtask

	task automatic load_const(input logic [4:0] r, input logic [31:0] value);
		emit(i_type(mips_pkg::OP_LUI, 5'd0, r, value[31:16]));
		emit(i_type(mips_pkg::OP_ORI, r, r, value[15:0]));
	endtask

	// Every store gets its own address, so a skipped one leaves a gap in the sequence.
	task automatic store_word(input string name, input logic [4:0] r, input logic [31:0] value,
			input logic expected);
		emit(i_type(mips_pkg::OP_SW, 5'd0, r, store_addr[15:0]));
		if (expected) begin
			exp_addr.push_back(store_addr);
			exp_data.push_back(value);
			exp_name.push_back(name);
		end
		store_addr += 32'd4;
	endtask

	task automatic alu_case(input logic [31:0] word);
		logic [31:0] a;
		logic [31:0] b;
		a = next_random();
		b = next_random();
		load_const(5'd1, a);
		load_const(5'd2, b);
		emit(word);
		store_word($sformatf("alu %h", word), 5'd3, expected_result(word, a, b), 1'b1);
	endtask

	task automatic build_program();
		logic [31:0] rnd;
		logic [31:0] a;
		logic [31:0] link;
		logic        taken;
		for (int i = 0; i < 1024; i++) begin
			imem[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			dmem[i] = xorshift(32'hd47a_0000 | 32'(i));
		end
		for (int round = 0; round < 2; round++) begin
			foreach (r_functs[k]) begin
				rnd = next_random();
				alu_case(r_type(r_functs[k], 5'd1, 5'd2, 5'd3, rnd[10:6]));
			end
			foreach (i_ops[k]) begin
				rnd = next_random();
				alu_case(i_type(i_ops[k], 5'd1, 5'd3, rnd[15:0]));
			end
		end
		for (int k = 0; k < 4; k++) begin
			a = next_random();
			load_const(5'd1, a);
			load_const(5'd2, k[0] ? a : ~a); // Bit 0 makes the operands equal.
			taken = k[1] ? !k[0] : k[0];
			emit(i_type(k[1] ? mips_pkg::OP_BNE : mips_pkg::OP_BEQ, 5'd1, 5'd2, 16'd1));
			store_word($sformatf("branch %0d marker", k), 5'd1, a, !taken);
			store_word($sformatf("branch %0d follow", k), 5'd2, k[0] ? a : ~a, 1'b1);
		end
		emit(j_type(mips_pkg::OP_J, 32'((pc_idx + 2) * 4)));
		store_word("j skipped", 5'd1, '0, 1'b0);
		link = 32'(pc_idx * 4) + 32'd8;
		emit(j_type(mips_pkg::OP_JAL, 32'((pc_idx + 3) * 4)));
		store_word("jal skipped", 5'd1, '0, 1'b0);
		store_word("jal skipped", 5'd2, '0, 1'b0);
		store_word("jal link", 5'd31, link, 1'b1);
		load_const(5'd8, 32'h140);
		for (int k = 0; k < 4; k++) begin
			emit(i_type(mips_pkg::OP_LW, 5'd8, 5'd7, 16'hffc0 + 16'(4 * k)));
			store_word($sformatf("lw word %0d", k), 5'd7, dmem[64 + k], 1'b1);
		end
		halt_addr = 32'(pc_idx * 4);
		emit(j_type(mips_pkg::OP_J, halt_addr)); // Jumps to itself.
		prog_len = pc_idx;
	endtask

	always @(posedge clk) begin
		stall_rng <= xorshift(stall_rng);
	end

	always @(posedge clk) begin
		if (rst) begin
			inst_req_ack <= 1'b0;
			inst_valid <= 1'b0;
			fetch_busy <= 1'b0;
		end else begin
			inst_req_ack <= inst_req_valid && !inst_req_ack && stall_rng[0];
			if (inst_req_valid && inst_req_ack) begin
				fetch_busy <= 1'b1;
				fetch_addr <= pc;
			end
			if (inst_valid && inst_ack) begin
				inst_valid <= 1'b0;
				fetch_busy <= 1'b0;
				instruction <= stall_rng; // Junk until the next word is ready.
			end else if (fetch_busy && !inst_valid && stall_rng[1]) begin
				inst_valid <= 1'b1;
				instruction <= imem[fetch_addr[11:2]];
			end
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			mem_req_ack <= 1'b0;
			read_data_valid <= 1'b0;
			load_busy <= 1'b0;
		end else begin
			mem_req_ack <= (mem_write || mem_read) && !mem_req_ack && stall_rng[2];
			if (mem_read && mem_req_ack) begin
				load_busy <= 1'b1;
				load_addr <= address;
			end
			if (read_data_valid && read_data_ack) begin
				read_data_valid <= 1'b0;
				load_busy <= 1'b0;
				read_data <= stall_rng;
			end else if (load_busy && !read_data_valid && stall_rng[3]) begin
				read_data_valid <= 1'b1;
				read_data <= dmem[load_addr[9:2]];
			end
		end
	end

	always @(posedge clk) begin
		if (!rst && !fetched_once) begin
			compare("reset strobes", 32'h0, {28'h0, inst_ack, mem_write, mem_read, read_data_ack});
			if (inst_req_valid === 1'b1) begin
				compare("first fetch pc", 32'h0, pc);
				fetched_once <= 1'b1;
			end
		end
		if (inst_req_valid && inst_req_ack && pc == halt_addr) begin
			halted <= 1'b1;
		end
	end

	always @(posedge clk) begin
		if (!rst && mem_write && mem_req_ack) begin
			if (exp_addr.size() == 0) begin
				abort($sformatf("store to %h with data %h was not expected", address, write_data));
			end else begin
				compare({exp_name[0], " address"}, exp_addr.pop_front(), address);
				compare({exp_name[0], " data"}, exp_data.pop_front(), write_data);
				void'(exp_name.pop_front());
			end
		end
	end

	initial begin
		wait (prog_len != 0);
		repeat (16 + prog_len * 40) @(posedge clk);
		abort("timeout: the program never reached its final jump");
	end

	initial begin
		build_program();
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		wait (halted);
		if (exp_addr.size() == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			abort($sformatf("%0d expected stores never happened", exp_addr.size()));
		end
	end

endmodule
